/* dv/fpTrace.txt */
# L reg data | I word kind reg value flags | S reg value | W cycles | T stall cycles
# kind 0 none, 1 result, 2 compare, 3 exception only; flags bit0 invalid, bit1 overflow
L 1 3f800000
L 2 40000000
L 3 bfc00000
L 5 7f000000
L 6 7f800001
L 7 33c00000
S 3 bfc00000
I 46001a86 1 10 bfc00000 0
I 46001ac5 1 11 3fc00000 0
I 46000b07 1 12 bf800000 0
I 46020b40 1 13 40400000 0
I 46031381 1 14 40600000 0
T 3
I 46030bc0 1 15 bf000000 0
I 46031c01 1 16 00000000 0
I 46070c40 1 17 3f800000 0
I 46052c80 1 18 7f800000 2
I 460134c0 1 19 7fc00000 1
I 4601183c 2 0 1 0
I 4603083c 2 0 0 0
I 46010832 2 0 1 0
I 4601103e 2 0 0 0
I 46013031 2 0 1 0
I 46220d00 3 20 0 1
I 46020d42 3 21 0 1
I 00221820 0 0 0 0
W 6
S 10 bfc00000
S 11 3fc00000
S 12 bf800000
S 14 40600000
S 16 00000000
S 18 7f800000
S 19 7fc00000
S 20 00000000
S 21 00000000
S 0 00000000

/* dv/fpUnitTb.sv */
`timescale 1ns/1ps

module fpUnitTb;
  import fpPkg::*;

  localparam string TraceFile = "dv/fpTrace.txt";

  logic        phi1 = 1'b0;
  logic        rstN;
  logic        stall;
  logic        instrValid;
  logic [31:0] instr;
  logic        loadEn;
  logic [4:0]  loadReg;
  logic [31:0] loadData;
  logic [4:0]  storeReg;
  logic [31:0] storeData;
  logic        resultValid;
  logic [4:0]  resultReg;
  logic [31:0] resultData;
  logic        cmpValid;
  logic        cmpFlag;
  logic [1:0]  excFlags;
  logic        fpExcept;

  int cycles     = 0;
  int cycleLimit = 1000;                 // Replaced once the trace is scanned
  int errCount   = 0;
  int doneCount  = 0;
  int storeCount = 0;

  // Outstanding completions, oldest first
  int          dueQ[$];                  // Cycle count at which it must show
  int          kindQ[$];                 // 1 result, 2 compare, 3 exception only
  logic [4:0]  regQ[$];
  logic [31:0] valQ[$];
  logic [1:0]  flagQ[$];

  fpUnit UUT (.*);

  always #2 phi1 = ~phi1;                // 4 ns period

  // Cycle counter and watchdog
  always @(posedge phi1) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("Timeout after %0d cycles, trace did not complete", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic checkResult(input logic [4:0] gotReg, input logic [31:0] gotData,
                             input logic [4:0] expReg, input logic [31:0] expData);
    if (gotReg !== expReg || gotData !== expData) begin
      $display("ERR %0t: result f%0d=%h, expected f%0d=%h", $time, gotReg, gotData,
               expReg, expData);
      errCount++;
    end
  endtask

  task automatic checkCmp(input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t: cmpFlag=%b, expected %b", $time, got, exp);
      errCount++;
    end
  endtask

  task automatic checkFlags(input logic [1:0] got, input logic gotExcept,
                            input logic [1:0] exp);
    if (got !== exp || gotExcept !== (|exp)) begin
      $display("ERR %0t: excFlags=%b fpExcept=%b, expected %b", $time, got, gotExcept, exp);
      errCount++;
    end
  endtask

  task automatic checkStore(input logic [4:0] r, input logic [31:0] got,
                            input logic [31:0] exp);
    storeCount++;
    if (got !== exp) begin
      $display("ERR %0t: store f%0d=%h, expected %h", $time, r, got, exp);
      errCount++;
    end
  endtask

  // Runs at each falling edge, outputs settled
  task automatic checkOutputs();
    int due;
    int kind;
    logic [4:0]  expReg;
    logic [31:0] expVal;
    logic [1:0]  expFlags;
    if (resultValid || cmpValid || fpExcept) begin
      if (dueQ.size() == 0) begin
        $display("Output pulse at %0t with no instruction outstanding", $time);
        errCount++;
      end else begin
        due      = dueQ.pop_front();
        kind     = kindQ.pop_front();
        expReg   = regQ.pop_front();
        expVal   = valQ.pop_front();
        expFlags = flagQ.pop_front();
        doneCount++;
        if (due != cycles) begin
          $display("ERR %0t: completion at cycle %0d, expected cycle %0d", $time, cycles, due);
          errCount++;
        end
        if (resultValid !== (kind == 1) || cmpValid !== (kind == 2)) begin
          $display("Wrong kind of completion at %0t: resultValid=%b cmpValid=%b, kind %0d",
                   $time, resultValid, cmpValid, kind);
          errCount++;
        end else if (kind == 1) begin
          checkResult(resultReg, resultData, expReg, expVal);
        end else if (kind == 2) begin
          checkCmp(cmpFlag, expVal[0]);
        end
        checkFlags(excFlags, fpExcept, expFlags);
      end
    end else if (dueQ.size() > 0 && dueQ[0] < cycles) begin
      $display("Completion due at cycle %0d never arrived", dueQ[0]);
      errCount++;
      void'(dueQ.pop_front());
      void'(kindQ.pop_front());
      void'(regQ.pop_front());
      void'(valQ.pop_front());
      void'(flagQ.pop_front());
    end
  endtask

  task automatic nextCycle();
    @(negedge phi1);
    checkOutputs();
  endtask

  // One command per call, '#' lines skipped
  task automatic readCmd(input int fd, output logic [7:0] cmd, output logic [31:0] a0,
                         output logic [31:0] a1, output logic [31:0] a2,
                         output logic [31:0] a3, output logic [31:0] a4, output bit ok);
    logic [7:0] ch;
    int n;
    int c;
    ok  = 1'b0;
    cmd = 8'd0;
    a0  = '0;
    a1  = '0;
    a2  = '0;
    a3  = '0;
    a4  = '0;
    n   = $fscanf(fd, " %c", ch);
    while (n == 1 && ch == "#") begin
      c = $fgetc(fd);
      while (c != "\n" && c != -1) begin
        c = $fgetc(fd);
      end
      n = $fscanf(fd, " %c", ch);
    end
    if (n == 1) begin
      cmd = ch;
      case (ch)
        "L", "S": n = $fscanf(fd, "%d %h", a0, a1);
        "I":      n = $fscanf(fd, "%h %d %d %h %d", a0, a1, a2, a3, a4);
        "W", "T": n = $fscanf(fd, "%d", a0);
        default:  n = 1;                 // Reported by the runner
      endcase
      ok = n > 0;
    end
  endtask

  // Trace length in cycles, for the watchdog
  task automatic scanTrace(output int total, output bit opened);
    int fd;
    logic [7:0]  cmd;
    logic [31:0] a0, a1, a2, a3, a4;
    bit ok;
    total  = 16;                         // Reset and drain
    fd     = $fopen(TraceFile, "r");
    opened = fd != 0;
    if (opened) begin
      readCmd(fd, cmd, a0, a1, a2, a3, a4, ok);
      while (ok) begin
        total += (cmd == "W" || cmd == "T") ? a0 : 1;
        readCmd(fd, cmd, a0, a1, a2, a3, a4, ok);
      end
      $fclose(fd);
    end
  endtask

  task automatic runTrace();
    int fd;
    logic [7:0]  cmd;
    logic [31:0] a0, a1, a2, a3, a4;
    bit ok;
    fd = $fopen(TraceFile, "r");
    readCmd(fd, cmd, a0, a1, a2, a3, a4, ok);
    while (ok) begin
      case (cmd)
        "L": begin
          loadEn   = 1'b1;
          loadReg  = a0[4:0];
          loadData = a1;
          nextCycle();
          loadEn   = 1'b0;
        end
        "I": begin
          instrValid = 1'b1;
          instr      = a0;
          if (a1 != 0) begin             // Kind 0 expects silence
            dueQ.push_back(cycles + 3);
            kindQ.push_back(a1);
            regQ.push_back(a2[4:0]);
            valQ.push_back(a3);
            flagQ.push_back(a4[1:0]);
          end
          nextCycle();
          instrValid = 1'b0;
        end
        "S": begin
          storeReg = a0[4:0];
          nextCycle();
          checkStore(a0[4:0], storeData, a1);
        end
        "W": repeat (a0) nextCycle();
        "T": begin
          stall = 1'b1;
          repeat (a0) begin
            for (int i = 0; i < dueQ.size(); i++) begin
              dueQ[i] = dueQ[i] + 1;     // Frozen edge pushes everything back
            end
            nextCycle();
          end
          stall = 1'b0;
        end
        default: begin
          $display("Unknown trace command '%c'", cmd);
          errCount++;
        end
      endcase
      readCmd(fd, cmd, a0, a1, a2, a3, a4, ok);
    end
    $fclose(fd);
  endtask

  initial begin
    int total;
    bit traceOk;
    rstN       = 1'b0;
    stall      = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    loadEn     = 1'b0;
    loadReg    = '0;
    loadData   = '0;
    storeReg   = '0;
    scanTrace(total, traceOk);
    cycleLimit = 4 * total + 100;
    if (!traceOk) begin
      $display("Could not open trace file %s", TraceFile);
      errCount++;
    end
    repeat (8) @(negedge phi1);          // 8 reset edges
    rstN = 1'b1;
    if (traceOk) begin
      runTrace();
    end
    repeat (8) nextCycle();
    if (dueQ.size() != 0) begin
      $display("%0d expected completions still outstanding at end", dueQ.size());
      errCount += dueQ.size();
    end
    $display("Completions %0d, stores %0d, errors %0d", doneCount, storeCount, errCount);
    if (errCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* dv/fpUnit_assert.sv */
`timescale 1ns/1ps

module fpUnitAssert (
  input logic       phi1,
  input logic       rstN,
  input logic       stall,
  input logic       resultValid,
  input logic       cmpValid,
  input logic [1:0] excFlags,
  input logic       fpExcept
);

  // One completion kind per cycle
  assert property (@(posedge phi1) disable iff (!rstN) !(resultValid && cmpValid))
    else $error("resultValid and cmpValid high in the same cycle");

  // Frozen edge produces no pulse
  assert property (@(posedge phi1) disable iff (!rstN)
                   $past(stall) |-> !(resultValid || cmpValid || fpExcept))
    else $error("Valid or exception pulse right after a stall cycle");

  // Exception pulse carries a cause
  assert property (@(posedge phi1) disable iff (!rstN) fpExcept |-> (excFlags != 2'b00))
    else $error("fpExcept high with excFlags zero");

endmodule

bind fpUnit fpUnitAssert ctrlChecks (
  .phi1        (phi1),
  .rstN        (rstN),
  .stall       (stall),
  .resultValid (resultValid),
  .cmpValid    (cmpValid),
  .excFlags    (excFlags),
  .fpExcept    (fpExcept)
);

/* sources.f */
verilog/fpPkg.sv
verilog/fpDecode.sv
verilog/fpRegFile.sv
verilog/fpDatapath.sv
verilog/fpWriteback.sv
verilog/fpUnit.sv
dv/fpUnit_assert.sv
dv/fpUnitTb.sv

/* verilog/fpDatapath.sv */
`timescale 1ns/1ps

module fpDatapath (
  input  logic        phi1,
  input  logic        rstN,
  input  logic        stall,
  input  logic        decValid,
  input  fpPkg::fpOpE decOp,
  input  logic [2:0]  decCond,
  input  logic        decInvalid,
  input  logic [4:0]  fdSpec,
  input  logic [31:0] fsData,
  input  logic [31:0] ftData,
  output logic        exValid,
  output fpPkg::fpOpE exOp,
  output logic [31:0] exResult,
  output logic [4:0]  exFd,
  output logic        exCmp,
  output logic [1:0]  exFlags
);
  import fpPkg::*;

  logic [7:0]  expA;
  logic [7:0]  expB;
  logic [22:0] fracA;
  logic [22:0] fracB;
  logic [30:0] magA;
  logic [30:0] magB;
  logic        nanA;
  logic        nanB;
  logic        infA;
  logic        infB;
  logic        signB;                      // ft sign after SUB inversion
  logic        aBig;
  logic        bigSign;
  logic        effSub;
  logic [7:0]  bigExp;
  logic [7:0]  expDiff;
  logic [4:0]  shamt;
  logic [23:0] bigMan;
  logic [23:0] smallMan;
  logic [26:0] smallExt;
  logic [26:0] shifted;
  logic [26:0] alignMan;
  logic [27:0] sum;
  logic [27:0] normMan;
  logic [4:0]  lz;
  logic signed [9:0] resExp;
  logic [31:0] addResult;
  logic        addInvalid;
  logic        addOverflow;
  logic        isAdd;
  logic [2:0]  rel;                        // Unordered, equal, less by cond index
  logic [31:0] opResult;
  logic [1:0]  flagsNext;

  // Leading zero count of the raw sum (28 for zero)
  function automatic logic [4:0] lzc28(input logic [27:0] v);
    logic [4:0] n;
    logic       found;
    n     = 5'd28;
    found = 1'b0;
    for (int i = 27; i >= 0; i--) begin
      if (!found && v[i]) begin
        n     = 5'(27 - i);
        found = 1'b1;
      end
    end
    return n;
  endfunction

  // Unpack with denormals flushed to zero
  assign expA  = fsData[30:23];
  assign expB  = ftData[30:23];
  assign fracA = (expA == 8'd0) ? 23'd0 : fsData[22:0];
  assign fracB = (expB == 8'd0) ? 23'd0 : ftData[22:0];
  assign magA  = {expA, fracA};
  assign magB  = {expB, fracB};
  assign nanA  = (&expA) && (|fracA);
  assign nanB  = (&expB) && (|fracB);
  assign infA  = (&expA) && !(|fracA);
  assign infB  = (&expB) && !(|fracB);
  assign isAdd = (decOp == opAdd) || (decOp == opSub);
  assign signB = ftData[31] ^ (decOp == opSub);

  // Order by magnitude so the difference never goes negative
  assign aBig     = magA >= magB;
  assign bigSign  = aBig ? fsData[31] : signB;
  assign effSub   = fsData[31] ^ signB;
  assign bigExp   = aBig ? expA : expB;
  assign expDiff  = aBig ? (expA - expB) : (expB - expA);
  assign bigMan   = aBig ? {|expA, fracA} : {|expB, fracB};    // Hidden bit
  assign smallMan = aBig ? {|expB, fracB} : {|expA, fracA};

  // Align with guard bits and fold sticky into the lsb
  assign shamt    = (expDiff > 8'd27) ? 5'd27 : expDiff[4:0];
  assign smallExt = {smallMan, 3'b000};
  assign shifted  = smallExt >> shamt;
  assign alignMan = {shifted[26:1], shifted[0] | (|(smallExt & ~({27{1'b1}} << shamt)))};

  assign sum     = effSub ? ({1'b0, bigMan, 3'b000} - {1'b0, alignMan})
                          : ({1'b0, bigMan, 3'b000} + {1'b0, alignMan});
  assign lz      = lzc28(sum);
  assign normMan = sum << lz;                         // Leading one at bit 27
  assign resExp  = $signed({2'b00, bigExp}) + 10'sd1 - $signed({5'd0, lz});

  always_comb begin
    addInvalid  = 1'b0;
    addOverflow = 1'b0;
    if (nanA || nanB || (infA && infB && effSub)) begin
      addResult  = CanonNan;
      addInvalid = 1'b1;
    end else if (infA || infB) begin
      addResult = {bigSign, 8'hFF, 23'd0};            // Infinity passes through
    end else if (sum == 28'd0) begin
      addResult = {bigSign & ~effSub, 31'd0};         // x - x is +0
    end else if (resExp >= 10'sd255) begin
      addResult   = {bigSign, 8'hFF, 23'd0};
      addOverflow = 1'b1;
    end else if (resExp <= 10'sd0) begin
      addResult = {bigSign, 31'd0};                   // Tiny result flushed
    end else begin
      addResult = {bigSign, resExp[7:0], normMan[26:4]};   // Truncated
    end
  end

  // Compare relations on flushed operands
  always_comb begin
    rel[CondUnordered] = nanA || nanB;
    rel[CondEqual]     = !(nanA || nanB) && (magA == magB) &&
                         ((fsData[31] == ftData[31]) || (magA == 31'd0));
    if (nanA || nanB || ((magA == 31'd0) && (magB == 31'd0))) begin
      rel[CondLess] = 1'b0;                           // +0 and -0 equal
    end else if (fsData[31] != ftData[31]) begin
      rel[CondLess] = fsData[31];
    end else begin
      rel[CondLess] = fsData[31] ? (magA > magB) : (magA < magB);
    end
  end

  always_comb begin
    case (decOp)
      opAdd, opSub: opResult = addResult;
      opAbs:        opResult = {1'b0, fsData[30:0]};
      opMov:        opResult = fsData;
      opNeg:        opResult = {~fsData[31], fsData[30:0]};
      default:      opResult = 32'd0;
    endcase
    flagsNext              = 2'b00;
    flagsNext[ExcInvalid]  = decInvalid || (isAdd && addInvalid);
    flagsNext[ExcOverflow] = isAdd && addOverflow;
  end

  always_ff @(posedge phi1) begin
    if (!rstN) begin
      exValid <= 1'b0;
      exOp    <= opNone;
      exCmp   <= 1'b0;
      exFlags <= 2'b00;
    end else if (!stall) begin
      exValid <= decValid;
      exOp    <= decOp;
      exCmp   <= |(decCond & rel);                    // Mask ANDed with relations
      exFlags <= flagsNext;
    end
  end

  always_ff @(posedge phi1) begin
    if (!stall) begin
      exResult <= opResult;
      exFd     <= fdSpec;
    end
  end

endmodule

/* verilog/fpDecode.sv */
`timescale 1ns/1ps

module fpDecode (
  input  logic        phi1,
  input  logic        rstN,
  input  logic        stall,
  input  logic        instrValid,
  input  logic [31:0] instr,
  output logic        decValid,
  output fpPkg::fpOpE decOp,
  output logic [2:0]  decCond,
  output logic        decInvalid,
  output logic [4:0]  fsSpec,
  output logic [4:0]  ftSpec,
  output logic [4:0]  fdSpec
);
  import fpPkg::*;

  logic [5:0] func;
  logic       isCop1;
  logic       fmtOk;
  logic       badFunc;
  fpOpE       opNext;

  assign isCop1 = instr[OpcodeLsb +: 6] == OpcodeCop1;
  assign fmtOk  = instr[FmtLsb +: 4] == FmtSingle;   // Double and fixed rejected
  assign func   = instr[5:0];

  // Function code to operation
  always_comb begin
    badFunc = 1'b0;
    if (func[5:4] == 2'b11) begin
      opNext = opCmp;                                 // Whole compare family
    end else begin
      case (func)
        FuncAdd: opNext = opAdd;
        FuncSub: opNext = opSub;
        FuncAbs: opNext = opAbs;
        FuncMov: opNext = opMov;
        FuncNeg: opNext = opNeg;
        default: begin
          opNext  = opNone;                           // MUL, DIV, CVT land here
          badFunc = 1'b1;
        end
      endcase
    end
  end

  // Control part of the decode register
  always_ff @(posedge phi1) begin
    if (!rstN) begin
      decValid   <= 1'b0;
      decOp      <= opNone;
      decInvalid <= 1'b0;
    end else if (!stall) begin
      decValid   <= instrValid && isCop1;             // Other opcodes ignored
      decOp      <= (fmtOk && !badFunc) ? opNext : opNone;
      decInvalid <= !fmtOk || badFunc;
    end
  end

  // Specifiers and condition mask
  always_ff @(posedge phi1) begin
    if (!stall) begin
      decCond <= func[2:0];
      fsSpec  <= instr[FsLsb +: 5];
      ftSpec  <= instr[FtLsb +: 5];
      fdSpec  <= instr[FdLsb +: 5];
    end
  end

endmodule

/* verilog/fpPkg.sv */
package fpPkg;

  // Instruction field positions
  localparam int OpcodeLsb = 26;          // Major opcode in 31:26
  localparam int FmtLsb    = 21;          // Format in 24:21
  localparam int FtLsb     = 16;          // ft in 20:16
  localparam int FsLsb     = 11;          // fs in 15:11
  localparam int FdLsb     = 6;           // fd in 10:6

  localparam logic [5:0] OpcodeCop1 = 6'h11;   // Marks FP instructions
  localparam logic [3:0] FmtSingle  = 4'h0;    // Only format handled

  // Function codes in bits 5:0
  localparam logic [5:0] FuncAdd = 6'h00;
  localparam logic [5:0] FuncSub = 6'h01;
  localparam logic [5:0] FuncAbs = 6'h05;
  localparam logic [5:0] FuncMov = 6'h06;
  localparam logic [5:0] FuncNeg = 6'h07;

  // Compare is 6'b11xxxx, low three bits pick the relations
  localparam int CondUnordered = 0;
  localparam int CondEqual     = 1;
  localparam int CondLess      = 2;

  typedef enum logic [2:0] {
    opNone,                               // Invalid or unknown
    opAdd,
    opSub,
    opAbs,
    opMov,
    opNeg,
    opCmp
  } fpOpE;

  // Bits of the 2-bit exception flag vector
  localparam int ExcInvalid  = 0;
  localparam int ExcOverflow = 1;

  localparam int NumRegs = 32;

  localparam logic [31:0] CanonNan = 32'h7FC0_0000;   // Quiet NaN result

endpackage

/* verilog/fpRegFile.sv */
`timescale 1ns/1ps

module fpRegFile (
  input  logic        phi1,
  input  logic        rstN,
  input  logic [4:0]  fsSpec,
  input  logic [4:0]  ftSpec,
  input  logic [4:0]  storeReg,
  output logic [31:0] fsData,
  output logic [31:0] ftData,
  output logic [31:0] storeData,
  input  logic        wbWe,
  input  logic [4:0]  wbReg,
  input  logic [31:0] wbData,
  input  logic        loadEn,
  input  logic [4:0]  loadReg,
  input  logic [31:0] loadData
);
  import fpPkg::*;

  logic [31:0] regs [NumRegs];

  // Three asynchronous read ports
  assign fsData    = regs[fsSpec];        // Source s operand
  assign ftData    = regs[ftSpec];        // Source t operand
  assign storeData = regs[storeReg];      // Memory store path

  // Single write port shared by writeback and load
  always_ff @(posedge phi1) begin
    if (!rstN) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wbWe) begin
      regs[wbReg] <= wbData;              // Writeback wins a collision
    end else if (loadEn) begin
      regs[loadReg] <= loadData;
    end
  end

endmodule

/* verilog/fpUnit.sv */
`timescale 1ns/1ps

module fpUnit (
  input  logic        phi1,
  input  logic        rstN,
  input  logic        stall,
  input  logic        instrValid,
  input  logic [31:0] instr,
  input  logic        loadEn,
  input  logic [4:0]  loadReg,
  input  logic [31:0] loadData,
  input  logic [4:0]  storeReg,
  output logic [31:0] storeData,
  output logic        resultValid,
  output logic [4:0]  resultReg,
  output logic [31:0] resultData,
  output logic        cmpValid,
  output logic        cmpFlag,
  output logic [1:0]  excFlags,
  output logic        fpExcept
);
  import fpPkg::*;

  // Decode stage
  logic        decValid;
  fpOpE        decOp;
  logic [2:0]  decCond;
  logic        decInvalid;
  logic [4:0]  fsSpec;
  logic [4:0]  ftSpec;
  logic [4:0]  fdSpec;
  logic [31:0] fsData;
  logic [31:0] ftData;

  // Execute stage
  logic        exValid;
  fpOpE        exOp;
  logic [31:0] exResult;
  logic [4:0]  exFd;
  logic        exCmp;
  logic [1:0]  exFlags;

  // Writeback into the register file
  logic        wbWe;
  logic [4:0]  wbReg;
  logic [31:0] wbData;

  fpDecode fpDecode (
    .phi1       (phi1),
    .rstN       (rstN),
    .stall      (stall),
    .instrValid (instrValid),
    .instr      (instr),
    .decValid   (decValid),
    .decOp      (decOp),
    .decCond    (decCond),
    .decInvalid (decInvalid),
    .fsSpec     (fsSpec),
    .ftSpec     (ftSpec),
    .fdSpec     (fdSpec)
  );

  fpRegFile fpRegFile (
    .phi1      (phi1),
    .rstN      (rstN),
    .fsSpec    (fsSpec),
    .ftSpec    (ftSpec),
    .storeReg  (storeReg),
    .fsData    (fsData),
    .ftData    (ftData),
    .storeData (storeData),
    .wbWe      (wbWe),
    .wbReg     (wbReg),
    .wbData    (wbData),
    .loadEn    (loadEn),
    .loadReg   (loadReg),
    .loadData  (loadData)
  );

  fpDatapath fpDatapath (
    .phi1       (phi1),
    .rstN       (rstN),
    .stall      (stall),
    .decValid   (decValid),
    .decOp      (decOp),
    .decCond    (decCond),
    .decInvalid (decInvalid),
    .fdSpec     (fdSpec),
    .fsData     (fsData),
    .ftData     (ftData),
    .exValid    (exValid),
    .exOp       (exOp),
    .exResult   (exResult),
    .exFd       (exFd),
    .exCmp      (exCmp),
    .exFlags    (exFlags)
  );

  fpWriteback fpWriteback (
    .phi1        (phi1),
    .rstN        (rstN),
    .stall       (stall),
    .exValid     (exValid),
    .exOp        (exOp),
    .exResult    (exResult),
    .exFd        (exFd),
    .exCmp       (exCmp),
    .exFlags     (exFlags),
    .wbWe        (wbWe),
    .wbReg       (wbReg),
    .wbData      (wbData),
    .resultValid (resultValid),
    .resultReg   (resultReg),
    .resultData  (resultData),
    .cmpValid    (cmpValid),
    .cmpFlag     (cmpFlag),
    .excFlags    (excFlags),
    .fpExcept    (fpExcept)
  );

endmodule

/* verilog/fpWriteback.sv */
`timescale 1ns/1ps

module fpWriteback (
  input  logic        phi1,
  input  logic        rstN,
  input  logic        stall,
  input  logic        exValid,
  input  fpPkg::fpOpE exOp,
  input  logic [31:0] exResult,
  input  logic [4:0]  exFd,
  input  logic        exCmp,
  input  logic [1:0]  exFlags,
  output logic        wbWe,
  output logic [4:0]  wbReg,
  output logic [31:0] wbData,
  output logic        resultValid,
  output logic [4:0]  resultReg,
  output logic [31:0] resultData,
  output logic        cmpValid,
  output logic        cmpFlag,
  output logic [1:0]  excFlags,
  output logic        fpExcept
);
  import fpPkg::*;

  logic valueOp;

  assign valueOp = exOp inside {opAdd, opSub, opAbs, opMov, opNeg};   // opNone never writes

  always_ff @(posedge phi1) begin
    if (!rstN) begin
      resultValid <= 1'b0;
      cmpValid    <= 1'b0;
      cmpFlag     <= 1'b0;
      excFlags    <= 2'b00;
      fpExcept    <= 1'b0;
    end else if (stall) begin
      resultValid <= 1'b0;                  // Pulses stay one cycle wide
      cmpValid    <= 1'b0;
      fpExcept    <= 1'b0;
    end else begin
      resultValid <= exValid && valueOp;
      cmpValid    <= exValid && (exOp == opCmp);
      fpExcept    <= exValid && (|exFlags);
      if (exValid) begin
        excFlags <= exFlags;                // Sticks until next completion
      end
      if (exValid && (exOp == opCmp)) begin
        cmpFlag <= exCmp;
      end
    end
  end

  // Result payload
  always_ff @(posedge phi1) begin
    if (!stall) begin
      resultReg  <= exFd;
      resultData <= exResult;
    end
  end

  // Register file sees the write one edge after resultValid
  assign wbWe   = resultValid;
  assign wbReg  = resultReg;
  assign wbData = resultData;

endmodule
